// ==== design/mem_defs.svh ====
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// Data word width in bits.
`define MEM_WIDTH 16

// Internal banks, selected by the low address bits.
`define MEM_NUM_BANKS 4

// Rows per bank, selected by the high address bits.
`define MEM_NUM_ROWS 16

// Longest allowed gap between refresh pulses, in cycles.
`define MEM_REF_FREQ 32

`endif

// ==== design/mem_pkg.sv ====
`include "mem_defs.svh"

package mem_pkg;

  typedef logic [`MEM_WIDTH-1:0] data_t;

  typedef logic [$clog2(`MEM_NUM_BANKS)-1:0] bank_t;

  typedef logic [$clog2(`MEM_NUM_ROWS)-1:0] row_t;

  // Row in the high bits, bank in the low bits.
  typedef logic [$bits(row_t)+$bits(bank_t)-1:0] addr_t;

  typedef logic [$clog2(`MEM_REF_FREQ+1)-1:0] ref_cnt_t;

  typedef enum logic [1:0] {
    RESET_WAIT,
    CLEAR,
    RUN
  } ctrl_state_t;

endpackage

// ==== design/bank_if.sv ====
`timescale 1ns/1ps

interface bank_if import mem_pkg::*; ();

  logic  wr_en;
  logic  rd_en;
  logic  clear;
  bank_t bank;
  row_t  row;
  data_t wdata;

  // Read return path.
  logic  rd_vld;
  data_t rd_data;

  modport ctrl (
    output wr_en,
    output rd_en,
    output clear,
    output bank,
    output row,
    output wdata
  );

  modport array (
    input  wr_en,
    input  rd_en,
    input  clear,
    input  bank,
    input  row,
    input  wdata,
    output rd_vld,
    output rd_data
  );

endinterface

// ==== design/mem_ctrl_fsm.sv ====
`timescale 1ns/1ps

module mem_ctrl_fsm import mem_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   read,
  input  logic   write,
  input  logic   refr,
  input  addr_t  addr,
  input  data_t  din,
  output logic   ready,
  output logic   ref_vld,
  output bank_t  ref_bank,
  output row_t   ref_row,
  output logic   step,
  output logic   refr_seen,
  input  bank_t  cnt_bank,
  input  row_t   cnt_row,
  input  logic   wrap,
  bank_if.ctrl   bus
);

  ctrl_state_t state;
  ctrl_state_t state_nxt;
  logic        clearing;
  bank_t       addr_bank;
  row_t        addr_row;

  always_comb begin
    state_nxt = state;
    case (state)
      RESET_WAIT: state_nxt = CLEAR;
      CLEAR:      if (wrap) state_nxt = RUN;
      default:    state_nxt = RUN;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= RESET_WAIT;
    end else begin
      state <= state_nxt;
    end
  end

  assign clearing  = (state == CLEAR);
  assign ready     = (state == RUN);
  assign refr_seen = ready && refr;
  // One row per cycle while clearing, one position per accepted refresh.
  assign step      = clearing || refr_seen;

  assign addr_bank = addr[$bits(bank_t)-1:0];
  assign addr_row  = addr[$bits(addr_t)-1:$bits(bank_t)];

  assign bus.rd_en = ready && read;
  assign bus.wr_en = (ready && write) || clearing;
  assign bus.clear = clearing;
  assign bus.bank  = addr_bank;
  assign bus.row   = clearing ? cnt_row : addr_row;
  assign bus.wdata = din;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ref_vld <= 1'b0;
    end else begin
      ref_vld <= refr_seen;
    end
  end

  // Position reported before the counter steps past it.
  always_ff @(posedge clk) begin
    if (refr_seen) begin
      ref_bank <= cnt_bank;
      ref_row  <= cnt_row;
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(read && write));

  a_refr_no_access: assert property (@(posedge clk) disable iff (!rst_n)
    ready |-> !(refr && (read || write)));

endmodule

// ==== design/refresh_counter.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module refresh_counter import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  step,
  input  logic  refr_seen,
  input  logic  run,
  output bank_t cnt_bank,
  output row_t  cnt_row,
  output logic  wrap,
  output logic  ref_late
);

  ref_cnt_t timer;
  logic     bank_last;
  logic     row_last;

  assign bank_last = (cnt_bank == bank_t'(`MEM_NUM_BANKS-1));
  assign row_last  = (cnt_row == row_t'(`MEM_NUM_ROWS-1));

  // Clear sweep walks rows only; refresh walks banks first.
  assign wrap = step && row_last && (!run || bank_last);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_bank <= '0;
      cnt_row  <= '0;
    end else if (step) begin
      if (!run) begin
        cnt_row <= row_last ? '0 : cnt_row + 1'b1;
      end else begin
        cnt_bank <= bank_last ? '0 : cnt_bank + 1'b1;
        if (bank_last) begin
          cnt_row <= row_last ? '0 : cnt_row + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timer    <= '0;
      ref_late <= 1'b0;
    end else if (refr_seen || !run) begin
      timer    <= '0;
      ref_late <= 1'b0;
    end else if (timer != ref_cnt_t'(`MEM_REF_FREQ)) begin
      timer <= timer + 1'b1;
      if (timer == ref_cnt_t'(`MEM_REF_FREQ-1)) begin
        ref_late <= 1'b1;
      end
    end
  end

  a_timer_bound: assert property (@(posedge clk) disable iff (!rst_n)
    timer <= ref_cnt_t'(`MEM_REF_FREQ));

endmodule

// ==== design/bank_array.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module bank_array import mem_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  bank_if.array bus
);

  data_t row_word [`MEM_NUM_BANKS];
  bank_t s1_bank;
  logic  s1_vld;

  for (genvar b = 0; b < `MEM_NUM_BANKS; b++) begin : g_bank
    data_t mem [`MEM_NUM_ROWS];
    data_t row_q;
    logic  sel;

    assign sel = (bus.bank == bank_t'(b));

    // Clear hits the same row in every bank.
    always_ff @(posedge clk) begin
      if (bus.wr_en && (bus.clear || sel)) begin
        mem[bus.row] <= bus.clear ? '0 : bus.wdata;
      end
    end

    // Only the addressed bank is read.
    always_ff @(posedge clk) begin
      if (bus.rd_en && sel) begin
        row_q <= mem[bus.row];
      end
    end

    assign row_word[b] = row_q;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld     <= 1'b0;
      bus.rd_vld <= 1'b0;
    end else begin
      s1_vld     <= bus.rd_en;
      bus.rd_vld <= s1_vld;
    end
  end

  always_ff @(posedge clk) begin
    if (bus.rd_en) begin
      s1_bank <= bus.bank;
    end
  end

  // Second stage picks the word from the bank read in the first.
  always_ff @(posedge clk) begin
    if (s1_vld) begin
      bus.rd_data <= row_word[s1_bank];
    end
  end

  a_no_spurious_vld: assert property (@(posedge clk) disable iff (!rst_n)
    !bus.rd_en |-> ##2 !bus.rd_vld);

endmodule

// ==== design/banked_mem_top.sv ====
`timescale 1ns/1ps

module banked_mem_top import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  read,
  input  logic  write,
  input  logic  refr,
  input  addr_t addr,
  input  data_t din,
  output logic  ready,
  output logic  rd_vld,
  output data_t rd_dout,
  output logic  ref_vld,
  output bank_t ref_bank,
  output row_t  ref_row,
  output logic  ref_late
);

  logic  step;
  logic  refr_seen;
  bank_t cnt_bank;
  row_t  cnt_row;
  logic  wrap;

  bank_if bus_i ();

  mem_ctrl_fsm ctrl_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .read      (read),
    .write     (write),
    .refr      (refr),
    .addr      (addr),
    .din       (din),
    .ready     (ready),
    .ref_vld   (ref_vld),
    .ref_bank  (ref_bank),
    .ref_row   (ref_row),
    .step      (step),
    .refr_seen (refr_seen),
    .cnt_bank  (cnt_bank),
    .cnt_row   (cnt_row),
    .wrap      (wrap),
    .bus       (bus_i.ctrl)
  );

  // Row-only sweep until ready, then bank-first refresh order.
  refresh_counter refr_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .refr_seen (refr_seen),
    .run       (ready),
    .cnt_bank  (cnt_bank),
    .cnt_row   (cnt_row),
    .wrap      (wrap),
    .ref_late  (ref_late)
  );

  bank_array array_i (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (bus_i.array)
  );

  assign rd_vld  = bus_i.rd_vld;
  assign rd_dout = bus_i.rd_data;

endmodule

// ==== bench/clk_gen.sv ====
`timescale 1ns/1ps

module clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Reset held for five rising edges.
  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

// ==== bench/mem_checker.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module mem_checker import mem_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  read,
  input  logic  write,
  input  logic  refr,
  input  addr_t addr,
  input  data_t din,
  input  logic  ready,
  input  logic  rd_vld,
  input  data_t rd_dout,
  input  logic  ref_vld,
  input  bank_t ref_bank,
  input  row_t  ref_row,
  input  logic  ref_late,
  output int    value_errs,
  output int    other_errs,
  output int    pending
);

  // Cleared memory reads back as zero until written.
  data_t shadow [2**$bits(addr_t)];
  data_t rd_exp [$];
  int    rd_due [$];
  int    now;
  int    quiet;
  int    ref_due;
  bank_t ref_bank_exp;
  row_t  ref_row_exp;
  bank_t sweep_bank;
  row_t  sweep_row;
  logic  ready_seen;

  initial begin
    foreach (shadow[i]) shadow[i] = '0;
    now        = 0;
    quiet      = 0;
    ref_due    = -1;
    sweep_bank = '0;
    sweep_row  = '0;
    ready_seen = 1'b0;
    value_errs = 0;
    other_errs = 0;
    pending    = 0;
  end

  // Inputs change just after the rising edge, so the falling edge sees both sides settled.
  always @(negedge clk) begin
    if (!rst_n) begin
      ready_seen = 1'b0;
      if (ready || rd_vld || ref_vld || ref_late) begin
        $display("Error at %0t: an output is high while rst_n is low", $time);
        other_errs++;
      end
    end else begin
      // Once up, ready stays up until the next reset.
      if (ready) begin
        ready_seen = 1'b1;
      end else if (ready_seen) begin
        $display("Error at %0t: ready fell after it had risen", $time);
        other_errs++;
      end
      if (rd_due.size() > 0 && rd_due[0] == now) begin
        if (!rd_vld) begin
          $display("Error at %0t: rd_vld missing two cycles after a read", $time);
          other_errs++;
        end else if (rd_dout !== rd_exp[0]) begin
          $display("Fail t=%0t rd_dout expected %h actual %h", $time, rd_exp[0], rd_dout);
          value_errs++;
        end
        void'(rd_due.pop_front());
        void'(rd_exp.pop_front());
      end else if (rd_vld) begin
        $display("Error at %0t: rd_vld high with no read pending", $time);
        other_errs++;
      end
      if (ref_due == now) begin
        if (!ref_vld) begin
          $display("Error at %0t: ref_vld missing one cycle after refr", $time);
          other_errs++;
        end else if (ref_bank !== ref_bank_exp || ref_row !== ref_row_exp) begin
          $display("Fail t=%0t ref_bank:ref_row expected %0d:%0d actual %0d:%0d", $time,
                   ref_bank_exp, ref_row_exp, ref_bank, ref_row);
          value_errs++;
        end
      end else if (ref_vld) begin
        $display("Error at %0t: ref_vld high with no refr accepted", $time);
        other_errs++;
      end
      if (ref_late != (quiet >= `MEM_REF_FREQ)) begin
        $display("Fail t=%0t ref_late expected %b actual %b", $time,
                 quiet >= `MEM_REF_FREQ, ref_late);
        value_errs++;
      end
      // Commands seen now are accepted at the next rising edge.
      if (ready && write) begin
        shadow[addr] = din;
      end
      if (ready && read) begin
        rd_exp.push_back(shadow[addr]);
        rd_due.push_back(now + 2);
      end
      if (ready && refr) begin
        ref_bank_exp = sweep_bank;
        ref_row_exp  = sweep_row;
        ref_due      = now + 1;
        // Bank first, row when the bank wraps.
        if (sweep_bank == bank_t'(`MEM_NUM_BANKS-1)) begin
          sweep_row = sweep_row + 1'b1;
        end
        sweep_bank = sweep_bank + 1'b1;
        quiet      = 0;
      end else if (!ready) begin
        quiet = 0;
      end else if (quiet < `MEM_REF_FREQ) begin
        quiet++;
      end
    end
    now++;
    pending = rd_due.size() + ((ref_due >= now) ? 1 : 0);
  end

endmodule

// ==== bench/tb_top.sv ====
`timescale 1ns/1ps

`include "mem_defs.svh"

module tb_top import mem_pkg::*; ();

  // Target of the commands driven while ready is low.
  localparam addr_t PRE_ADDR = 6'h15;

  logic  clk;
  logic  rst_n;
  logic  read;
  logic  write;
  logic  refr;
  addr_t addr;
  data_t din;
  logic  ready;
  logic  rd_vld;
  data_t rd_dout;
  logic  ref_vld;
  bank_t ref_bank;
  row_t  ref_row;
  logic  ref_late;
  int    value_errs;
  int    other_errs;
  int    pending;
  int    open_errs = 0;
  int    cycles = 0;
  int    limit = 0;

  byte   op_q [$];
  addr_t addr_q [$];
  data_t data_q [$];
  int    idle_q [$];

  clk_gen clk_i (.*);

  banked_mem_top dut_i (.*);

  mem_checker chk_i (.*);

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    int               fd;
    int               n;
    int               idle;
    int               total;
    addr_t            a;
    data_t            d;
    string            tok;
    string            dtok;
    logic [8*128-1:0] rest;
    read     = 1'b0;
    write    = 1'b1;
    refr     = 1'b0;
    addr     = PRE_ADDR;
    din      = 16'hc3a5;
    void'($urandom(32'hd13a43f0));
    limit    = 50;
    fd       = $fopen("bench/mem_tests.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open bench/mem_tests.txt");
      open_errs = 1;
    end
    while (fd != 0 && !$feof(fd)) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) break;
      if (tok == "#") begin
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%h %s %d", a, dtok, idle);
        if (dtok == "x") begin
          d = data_t'($urandom);
        end else begin
          n = $sscanf(dtok, "%h", d);
        end
        op_q.push_back(tok.getc(0));
        addr_q.push_back(a);
        data_q.push_back(d);
        idle_q.push_back(idle);
        limit += 1 + idle;
      end
    end
    // Alternate write and read until ready; none of them may take effect.
    while (ready !== 1'b1) begin
      @(posedge clk);
      #1;
      if (ready) begin
        read  = 1'b0;
        write = 1'b0;
      end else begin
        write = read;
        read  = !write;
      end
    end
    for (int i = 0; i < op_q.size(); i++) begin
      addr  = addr_q[i];
      din   = data_q[i];
      write = (op_q[i] == "W");
      read  = (op_q[i] == "R");
      refr  = (op_q[i] == "F");
      @(posedge clk);
      #1;
      write = 1'b0;
      read  = 1'b0;
      refr  = 1'b0;
      repeat (idle_q[i]) begin
        @(posedge clk);
        #1;
      end
    end
    while (pending != 0) begin
      @(posedge clk);
    end
    @(negedge clk);
    total = value_errs + other_errs + open_errs;
    $display("Errors: %0d (wrong values %0d, other %0d)", total, value_errs,
             other_errs + open_errs);
    if (total == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/mem_pkg.sv
design/bank_if.sv
design/mem_ctrl_fsm.sv
design/refresh_counter.sv
design/bank_array.sv
design/banked_mem_top.sv
bench/clk_gen.sv
bench/mem_checker.sv
bench/tb_top.sv

// ==== Makefile ====
LOG = sim.log

all: run

run:
	verilator --binary --timing --assert -f project.f --top-module tb_top -Mdir obj_dir -o sim
	./obj_dir/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module banked_mem_top

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run lint clean

// ==== bench/mem_tests.txt ====
# op addr(hex) data(hex, or x for random) idle(cycles, decimal)
# W write, R read, F refresh, I idle; read data are predicted from earlier writes
R 00 0 0
R 15 0 0
R 3f 0 2
W 05 a5a5 0
R 05 0 0
W 04 1234 0
W 06 x 0
W 07 x 1
R 04 0 0
R 05 0 0
R 06 0 0
R 07 0 3
F 00 0 0
F 00 0 0
F 00 0 0
F 00 0 0
F 00 0 1
I 00 0 36
F 00 0 2
W 3c ffff 0
R 3c 0 0
R 38 0 0
R 15 0 4
